/* compile.f */
+incdir+source
source/fd1094_pkg.sv
source/fd1094_decrypt.sv
source/fd1094_bus_track.sv
source/fd1094_state_ctrl.sv
source/fd1094_top.sv
verif/fd1094_tb.sv

/* Makefile */
# Verilator flow for the fd1094 opcode decryption model

VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
TOP        := fd1094_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
PASS_MSG   := Everything OK

SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only if the testbench printed the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* verif/fd1094_tb.sv */
// fd1094 opcode decryption testbench
// runs fetch and data bus cycles into the top level and keeps its own
// model of the key table, state byte and interrupt mode
// every decrypted word and the active key byte are checked against it
`timescale 1ns/1ps
`include "fd1094_cfg.svh"

module fd1094_tb
    import fd1094_pkg::*;
();

    localparam int MAX_CYCLES = 2000;   // tests take about 270 cycles
    // cmpi.l #imm,abs.l
    localparam logic [15:0] CMPI_L = {`FD_CMPI_HI, `FD_CMPI_SZ, 6'h39};

    logic        clk = 1'b0;
    logic        rst;
    cpu_bus_t    bus;
    key_wr_t     key_wr;
    logic [15:0] dec;
    logic [7:0]  st;

    logic [7:0]  key_model [16];    // expected key table
    logic [7:0]  st_model;          // expected state byte
    logic        irq_model;         // expected interrupt mode
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles = 0;

    fd1094_top dut (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .key_wr (key_wr),
        .dec    (dec),
        .st     (st)
    );

    always #20 clk = ~clk;   // 40 ns period

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [23:1] rand_addr();
        logic [31:0] r;
        r = next_rand();
        return r[22:0];
    endfunction

    // random opcode word that neither arms the sequencer nor is an rte
    function automatic logic [15:0] rand_word();
        logic [31:0] r;
        logic [15:0] w;
        r = next_rand();
        w = r[15:0];
        if (w[15:8] == `FD_CMPI_HI) w[15:8] = 8'h0d;
        if (w == `FD_RTE) w = 16'h4e71;   // nop instead
        return w;
    endfunction

    // key byte the decrypter should be using
    function automatic logic [7:0] model_st();
        return irq_model ? key_model[0] : st_model;
    endfunction

    // xor mask is its own inverse, so this encrypts too
    function automatic logic [15:0] apply_mask(input logic [15:0] w, input logic [23:1] a);
        logic [7:0] k;
        k = key_model[a[4:1]];
        return w ^ {k, k ^ model_st()};
    endfunction

    // expected effect of a confirmed command with the mode in bits 9:8
    function automatic void apply_cmd(input logic [15:0] w);
        case (w[9:8])
            2'd0: st_model = w[7:0];
            2'd1: begin
                st_model  = 8'h00;
                irq_model = 1'b0;
            end
            2'd2: irq_model = 1'b1;
            default: irq_model = 1'b0;
        endcase
    endfunction

    task automatic check(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // sampled mid cycle after any state update has settled
    task automatic check_st(input string what);
        @(negedge clk);
        check(what, {8'h00, st}, {8'h00, model_st()});
    endtask

    // one opcode fetch with dec sampled while dtack is low
    task automatic fetch(input logic [23:1] a, input logic [15:0] plain,
                         output logic [15:0] seen);
        @(posedge clk);
        bus.addr   <= a;
        bus.enc    <= apply_mask(plain, a);
        bus.op_n   <= 1'b0;
        bus.dtackn <= 1'b1;
        @(posedge clk);
        bus.dtackn <= 1'b0;   // falling dtack
        @(negedge clk);
        seen = dec;
        @(posedge clk);
        bus.dtackn <= 1'b1;
        bus.op_n   <= 1'b1;
    endtask

    task automatic fetch_check(input logic [23:1] a, input logic [15:0] plain, input string what);
        logic [15:0] seen;
        fetch(a, plain, seen);
        check(what, seen, plain);
    endtask

    task automatic data_cycle(input logic [23:1] a);
        @(posedge clk);
        bus.addr   <= a;
        bus.op_n   <= 1'b1;   // not a fetch
        bus.dtackn <= 1'b1;
        @(posedge clk);
        bus.dtackn <= 1'b0;
        @(posedge clk);
        bus.dtackn <= 1'b1;
    endtask

    task automatic random_fetches(input int n, input string what);
        repeat (n) fetch_check(rand_addr(), rand_word(), what);
    endtask

    // cmpi.l followed by the command and the second immediate
    task automatic run_cmd(input logic [23:1] a, input logic [15:0] cmd,
                           input logic [15:0] second);
        fetch_check(a, CMPI_L, "cmpi fetch");
        fetch_check(a + 23'd1, cmd, "command word");
        fetch_check(a + 23'd2, second, "second immediate");
    endtask

    task automatic pulse_inta();
        @(posedge clk);
        bus.inta_n <= 1'b0;
        @(posedge clk);
        bus.inta_n <= 1'b1;
        irq_model = 1'b1;
    endtask

    task automatic plain_key_fetches();
        logic [31:0] r;
        check("st out of reset", {8'h00, st}, 16'h0000);
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            @(posedge clk);
            key_wr.we   <= 1'b1;
            key_wr.idx  <= i[3:0];
            key_wr.data <= r[7:0];
            key_model[i] = r[7:0];
        end
        @(posedge clk);
        key_wr.we <= 1'b0;
        random_fetches(24, "fetch with st 0");
    endtask

    task automatic set_state_sequence();
        run_cmd(23'h000100, {6'b0, SET_STATE, 8'h5a}, `FD_CONFIRM);
        apply_cmd({6'b0, SET_STATE, 8'h5a});
        check_st("st after set 5a");
        random_fetches(8, "fetch with st 5a");
        run_cmd(23'h000200, {6'b0, SET_STATE, 8'h33}, 16'h1234);   // not confirmed
        check_st("st after unconfirmed set");
        random_fetches(4, "fetch after unconfirmed set");
    endtask

    task automatic ignored_sequences();
        @(posedge clk);
        bus.sup_prog <= 1'b0;   // user program space
        run_cmd(23'h000300, {6'b0, SET_STATE, 8'ha5}, `FD_CONFIRM);
        @(posedge clk);
        bus.sup_prog <= 1'b1;
        check_st("st after user mode cmpi");
        // two data cycles in a row cancel the sequencer
        fetch_check(23'h000400, CMPI_L, "cmpi fetch");
        data_cycle(23'h010000);
        data_cycle(23'h010001);
        fetch_check(23'h000401, {6'b0, SET_STATE, 8'ha5}, "command word");
        fetch_check(23'h000402, `FD_CONFIRM, "second immediate");
        check_st("st after cancelled cmpi");
        // a single data cycle keeps it armed
        fetch_check(23'h000500, CMPI_L, "cmpi fetch");
        data_cycle(23'h010002);
        fetch_check(23'h000501, {6'b0, SET_STATE, 8'hc3}, "command word");
        fetch_check(23'h000502, `FD_CONFIRM, "second immediate");
        apply_cmd({6'b0, SET_STATE, 8'hc3});
        check_st("st after one data cycle");
    endtask

    task automatic irq_mode_switching();
        pulse_inta();
        check_st("st after inta");
        random_fetches(4, "fetch in irq mode");
        fetch_check(rand_addr(), `FD_RTE, "rte fetch");
        irq_model = 1'b0;
        check_st("st after rte");
        run_cmd(23'h000600, {6'b0, ENTER_IRQ, 8'h00}, `FD_CONFIRM);
        apply_cmd({6'b0, ENTER_IRQ, 8'h00});
        check_st("st after enter irq cmd");
        random_fetches(2, "fetch in irq mode");
        run_cmd(23'h000700, {6'b0, LEAVE_IRQ, 8'h00}, `FD_CONFIRM);
        apply_cmd({6'b0, LEAVE_IRQ, 8'h00});
        check_st("st after leave irq cmd");
    endtask

    task automatic reset_and_key_loss();
        logic [23:1] a;
        logic [15:0] w;
        logic [15:0] seen;
        pulse_inta();
        run_cmd(23'h000800, {6'b0, RESET_STATE, 8'h77}, `FD_CONFIRM);   // val ignored
        apply_cmd({6'b0, RESET_STATE, 8'h77});
        check_st("st after reset cmd");
        @(posedge clk);
        rst <= 1'b1;   // key table lost
        @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 16; i++) key_model[i] = 8'h00;
        st_model  = 8'h00;
        irq_model = 1'b0;
        repeat (6) begin
            a = rand_addr();
            w = rand_word();
            fetch(a, w, seen);
            check("dec after key loss", seen, w);
            check("dec equals enc", seen, bus.enc);
        end
    endtask

    initial begin
        rst    <= 1'b1;
        bus    <= '{addr: '0, enc: '0, op_n: 1'b1, dtackn: 1'b1,
                    inta_n: 1'b1, sup_prog: 1'b1};
        key_wr <= '0;
        rng       = 32'h9e80_948a;
        st_model  = 8'h00;
        irq_model = 1'b0;
        errors    = 0;
        checks    = 0;
        for (int i = 0; i < 16; i++) key_model[i] = 8'h00;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        plain_key_fetches();
        set_state_sequence();
        ignored_sequences();
        irq_mode_switching();
        reset_and_key_loss();

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* source/fd1094_top.sv */
// fd1094 opcode decryption, top level
// sits beside the 68000 core, decrypts fetched words on the fly
// the bus tracker and state control steer the key byte fed back
// into the decrypter
`timescale 1ns/1ps

module fd1094_top
    import fd1094_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    input  key_wr_t     key_wr,   // key loader
    output logic [15:0] dec,      // plain word to the cpu
    output logic [7:0]  st
);

    logic [7:0] gkey0;
    bus_evt_t   evt;

    fd1094_decrypt u_decrypt (
        .clk    (clk),
        .rst    (rst),
        .key_wr (key_wr),
        .addr   (bus.addr),
        .enc    (bus.enc),
        .st     (st),
        .dec    (dec),
        .gkey0  (gkey0)
    );

    fd1094_bus_track u_bus_track (
        .clk (clk),
        .rst (rst),
        .bus (bus),
        .dec (dec),
        .evt (evt)
    );

    fd1094_state_ctrl u_state_ctrl (
        .clk    (clk),
        .rst    (rst),
        .evt    (evt),
        .dec    (dec),
        .inta_n (bus.inta_n),
        .gkey0  (gkey0),
        .st     (st)
    );

endmodule

/* source/fd1094_state_ctrl.sv */
// fd1094 decryption state control
// keeps the state byte and the interrupt mode flag
// first immediate after cmpi.l is latched as a command, the
// second one must be the confirm word for it to act
// in interrupt mode the global key replaces the state
`timescale 1ns/1ps
`include "fd1094_cfg.svh"

module fd1094_state_ctrl
    import fd1094_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  bus_evt_t   evt,
    input  fd_word_u   dec,
    input  logic       inta_n,
    input  logic [7:0] gkey0,
    output logic [7:0] st       // key byte used by the decrypter
);

    logic [7:0] state;
    logic       irq_mode;
    fd_word_u   cmd_word;   // pending command from imm1
    logic       confirm;

    assign confirm = evt.imm2 && dec == `FD_CONFIRM;

    // command word, only meaningful between imm1 and imm2
    always_ff @(posedge clk) begin
        if (evt.imm1) begin
            cmd_word <= dec;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= '0;
            irq_mode <= 1'b0;
        end else begin
            if (!inta_n) irq_mode <= 1'b1;   // irq ack
            if (evt.rte) irq_mode <= 1'b0;   // back from exception
            if (confirm) begin
                case (cmd_word.cmd.mode)
                    SET_STATE: state <= cmd_word.cmd.val;
                    RESET_STATE: begin
                        state    <= '0;
                        irq_mode <= 1'b0;
                    end
                    ENTER_IRQ: irq_mode <= 1'b1;
                    LEAVE_IRQ: irq_mode <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    assign st = irq_mode ? gkey0 : state;

    // state byte and key table both come out of reset defined
    a_st_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(st)
    ) else $error("st unknown");

endmodule

/* source/fd1094_bus_track.sv */
// fd1094 bus tracker
// finds the falling dtack edge of each bus cycle and qualifies
// supervisor opcode fetches on it
// a cmpi.l fetch arms a two-step sequencer that flags the
// two immediate words; two data cycles in a row cancel it
`timescale 1ns/1ps
`include "fd1094_cfg.svh"

module fd1094_bus_track
    import fd1094_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_bus_t bus,
    input  fd_word_u dec,   // decrypted word of the current fetch
    output bus_evt_t evt
);

    logic       dtackn_l;   // dtackn at the previous edge
    logic       dtack_fall;
    logic       qual;       // supervisor opcode fetch, once per cycle
    logic       is_cmpi;
    logic       is_rte;
    logic [1:0] seq;        // one-hot, bit 0 waits imm1, bit 1 waits imm2
    logic       prev_data;  // last completed cycle was not a fetch

    assign dtack_fall = dtackn_l && !bus.dtackn;
    assign qual       = dtack_fall && !bus.op_n && bus.sup_prog;

    // opcode view of the decrypted word
    assign is_cmpi = dec.op.hi == `FD_CMPI_HI && dec.op.sz == `FD_CMPI_SZ;
    assign is_rte  = dec == `FD_RTE;

    always_comb begin
        evt.imm1 = qual && seq[0];
        evt.imm2 = qual && seq[1];
        evt.rte  = qual && is_rte;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn_l  <= 1'b0;   // no false edge out of reset
            seq       <= 2'b00;
            prev_data <= 1'b0;
        end else begin
            dtackn_l <= bus.dtackn;
            if (qual && seq != 2'b00) begin
                seq <= seq << 1;   // imm1 -> imm2 -> idle
            end
            if (qual && is_cmpi) begin
                seq <= 2'b01;   // arming restarts the count
            end
            if (dtack_fall) begin
                prev_data <= bus.op_n;
                if (prev_data && bus.op_n) begin
                    seq <= 2'b00;   // second data cycle in a row
                end
            end
        end
    end

    // sequencer holds one step at a time
    a_imm_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(evt.imm1 && evt.imm2)
    ) else $error("imm1 and imm2 together");

endmodule

/* source/fd1094_decrypt.sv */
// fd1094 key table and word decryption
// 16 key bytes loaded from the key port, cleared on reset
// decryption is purely combinational, no added bus latency
// mask high byte is the addressed key, low byte is key ^ state
`timescale 1ns/1ps
`include "fd1094_cfg.svh"

module fd1094_decrypt
    import fd1094_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  key_wr_t     key_wr,
    input  logic [23:1] addr,
    input  logic [15:0] enc,
    input  logic [7:0]  st,     // active key byte from state ctrl
    output logic [15:0] dec,
    output logic [7:0]  gkey0   // global key, entry 0
);

    localparam int KEY_N = 1 << `FD_KEY_AW;

    logic [7:0]  key_tbl [KEY_N];
    logic [7:0]  key;           // entry picked by the fetch address
    logic [15:0] mask;

    // key loader port, one byte per clock
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < KEY_N; i++) begin
                key_tbl[i] <= '0;   // lost key decrypts as plain
            end
        end else if (key_wr.we) begin
            key_tbl[key_wr.idx] <= key_wr.data;
        end
    end

    // addr[4:1] selects the entry
    always_comb begin
        key  = key_tbl[addr[`FD_KEY_AW:1]];
        mask = {key, key ^ st};
    end

    assign dec   = enc ^ mask;   // same xor encrypts and decrypts
    assign gkey0 = key_tbl[0];

    // a loader write must always hit a defined entry
    a_key_idx_known: assert property (
        @(posedge clk) disable iff (rst)
        key_wr.we |-> !$isunknown(key_wr.idx)
    ) else $error("key write with unknown index");

endmodule

/* source/fd1094_pkg.sv */
// fd1094 shared types
// cpu bus bundle, key loader write, decoded word views, event pulses
`include "fd1094_cfg.svh"

package fd1094_pkg;

    typedef struct packed {
        logic [23:1] addr;      // word address A23..A1
        logic [15:0] enc;       // encrypted word as read from rom
        logic        op_n;      // opcode fetch strobe
        logic        dtackn;
        logic        inta_n;    // interrupt acknowledge cycle
        logic        sup_prog;  // supervisor program space
    } cpu_bus_t;

    typedef struct packed {
        logic                  we;
        logic [`FD_KEY_AW-1:0] idx;   // key table entry
        logic [7:0]            data;
    } key_wr_t;

    // state command, bits 9:8 of the first immediate
    typedef enum logic [1:0] {
        SET_STATE   = 2'd0,
        RESET_STATE = 2'd1,
        ENTER_IRQ   = 2'd2,
        LEAVE_IRQ   = 2'd3
    } st_mode_e;

    // one decrypted word, seen as opcode or as state command
    typedef union packed {
        struct packed {
            logic [7:0] hi;     // opcode byte
            logic [1:0] sz;     // size field
            logic [5:0] lo;     // ea bits
        } op;
        struct packed {
            logic [5:0] unused;
            st_mode_e   mode;
            logic [7:0] val;    // new state byte
        } cmd;
    } fd_word_u;

    typedef struct packed {
        logic imm1;   // first immediate after cmpi
        logic imm2;   // second immediate, confirm word
        logic rte;    // qualified rte fetch
    } bus_evt_t;

endpackage

/* source/fd1094_cfg.svh */
// fd1094 opcode decryption configuration
// key table size, opcodes watched on the bus and the confirm word
`ifndef FD1094_CFG_SVH
`define FD1094_CFG_SVH

// key table index width, 16 entries picked by addr[4:1]
`define FD_KEY_AW 4

// cmpi.l #imm,<ea> is 0x0c with size field 10
`define FD_CMPI_HI 8'h0c
`define FD_CMPI_SZ 2'b10

// rte, full opcode word
`define FD_RTE 16'h4e73

// second immediate must decode to this before a command acts
`define FD_CONFIRM 16'hffff

`endif
